//--- source/data_bus_if.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

interface data_bus_if import mips_pkg::*; ();

  logic               req;
  logic               wr;
  bus_size_t          size;
  logic [`RegBus-1:0] addr;
  logic [`RegBus-1:0] wdata;
  logic               addr_ok;
  logic               data_ok;
  logic [`RegBus-1:0] rdata;

  modport master (output req, wr, size, addr, wdata,
                  input  addr_ok, data_ok, rdata);

  modport slave  (input  req, wr, size, addr, wdata,
                  output addr_ok, data_ok, rdata);

endinterface

//--- source/data_ram.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module data_ram
  import mips_pkg::*;
(
  input logic       clk,
  input logic       rst,
  data_bus_if.slave bus
);

  localparam int unsigned DEPTH = 1 << `RAM_ADDR_BITS;

  logic [`RegBus-1:0]        mem [DEPTH];
  logic [`RAM_ADDR_BITS-1:0] word_addr;
  logic [3:0]                base_be;
  logic [3:0]                byte_en;
  logic                      accept;

  // always ready for a new address
  assign bus.addr_ok = 1'b1;
  assign accept      = bus.req && bus.addr_ok;
  assign word_addr   = bus.addr[`RAM_ADDR_BITS+1:2];

  // enable bit 3 is lane 31:24, offset 0
  always_comb begin
    case (bus.size)
      SZ_BYTE: base_be = 4'b1000;
      SZ_HALF: base_be = 4'b1100;
      default: base_be = 4'b1111;
    endcase
    byte_en = base_be >> bus.addr[1:0];
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if (bus.wr) begin
        for (int i = 0; i < 4; i++) begin
          if (byte_en[i]) begin
            mem[word_addr][i*8 +: 8] <= bus.wdata[i*8 +: 8];
          end
        end
      end
      bus.rdata <= mem[word_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.data_ok <= 1'b0;
    end else begin
      bus.data_ok <= accept;
    end
  end

endmodule

//--- source/mem_except.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mem_except
  import mips_pkg::*;
(
  input  logic                   rst,
  input  mem_op_t                aluop_i,
  input  logic [`RegBus-1:0]     mem_addr_i,
  input  logic [31:0]            except_i,
  input  logic [`RegBus-1:0]     cp0_status_i,
  input  logic [`RegBus-1:0]     cp0_cause_i,
  input  logic [`RegBus-1:0]     cp0_epc_i,
  input  logic                   wb_cp0_we_i,
  input  logic [`RegAddrBus-1:0] wb_cp0_waddr_i,
  input  logic [`RegBus-1:0]     wb_cp0_wdata_i,
  output logic                   kill_o,
  output exc_code_t              code_o,
  output logic [`RegBus-1:0]     epc_o
);

  logic [`RegBus-1:0] status;
  logic [`RegBus-1:0] cause;
  logic               int_req;
  logic               adel;
  logic               ades;

  // newest cp0 values with writeback winning
  always_comb begin
    status = cp0_status_i;
    cause  = cp0_cause_i;
    epc_o  = cp0_epc_i;
    if (wb_cp0_we_i) begin
      case (wb_cp0_waddr_i)
        `CP0_REG_STATUS: status = wb_cp0_wdata_i;
        // only the software interrupt bits are writable
        `CP0_REG_CAUSE:  cause[9:8] = wb_cp0_wdata_i[9:8];
        `CP0_REG_EPC:    epc_o = wb_cp0_wdata_i;
        default:         ;
      endcase
    end
  end

  // no interrupt while the core is held in reset
  assign int_req = !rst && (|(cause[15:8] & status[15:8])) && !status[1] && status[0];

  assign adel = (aluop_i inside {MOP_LH, MOP_LHU} && mem_addr_i[0]) ||
                (aluop_i == MOP_LW && mem_addr_i[1:0] != 2'b00);
  assign ades = (aluop_i == MOP_SH && mem_addr_i[0]) ||
                (aluop_i == MOP_SW && mem_addr_i[1:0] != 2'b00);

  always_comb begin
    if (int_req) begin
      code_o = EXC_INT;
    end else if (adel) begin
      code_o = EXC_ADEL;
    end else if (ades) begin
      code_o = EXC_ADES;
    end else if (except_i[8]) begin
      code_o = EXC_SYS;
    end else if (except_i[9]) begin
      code_o = EXC_RI;
    end else if (except_i[10]) begin
      code_o = EXC_TR;
    end else if (except_i[11]) begin
      code_o = EXC_OV;
    end else if (except_i[12]) begin
      code_o = EXC_ERET;
    end else begin
      code_o = EXC_NONE;
    end
  end

  assign kill_o = (code_o != EXC_NONE);

endmodule

//--- source/mem_lsu.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mem_lsu
  import mips_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  mem_op_t            aluop_i,
  input  logic [`RegBus-1:0] mem_addr_i,
  input  logic [`RegBus-1:0] reg2_i,
  input  logic [`RegBus-1:0] wdata_i,
  input  logic               kill_i,
  data_bus_if.master         bus,
  output logic               stall_o,
  output logic [`RegBus-1:0] result_o
);

  logic               is_store;
  logic               is_mem;
  logic               issue;
  logic               pending;
  logic [1:0]         offset;
  logic [`RegBus-1:0] rdata;
  logic [7:0]         rd_byte;
  logic [15:0]        rd_half;

  assign offset = mem_addr_i[1:0];
  assign rdata  = bus.rdata;

  assign is_store = aluop_i inside {MOP_SB, MOP_SH, MOP_SW};
  assign is_mem   = is_store ||
                    aluop_i inside {MOP_LB, MOP_LBU, MOP_LH, MOP_LHU,
                                    MOP_LW, MOP_LWL, MOP_LWR};

  // excepting ops never reach the bus
  assign issue   = is_mem && !kill_i;
  assign bus.req = issue && !pending;
  assign bus.wr  = is_store;

  // hold upstream until the answer is back
  assign stall_o = issue && !(pending && bus.data_ok);

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (bus.req && bus.addr_ok) begin
      pending <= 1'b1;
    end else if (bus.data_ok) begin
      pending <= 1'b0;
    end
  end

  // address, size and lane-replicated store data
  always_comb begin
    bus.addr  = mem_addr_i;
    bus.size  = SZ_WORD;
    bus.wdata = reg2_i;
    case (aluop_i)
      MOP_LB, MOP_LBU: begin
        bus.size = SZ_BYTE;
      end
      MOP_LH, MOP_LHU: begin
        bus.size = SZ_HALF;
      end
      MOP_LWL, MOP_LWR: begin
        bus.addr = {mem_addr_i[`RegBus-1:2], 2'b00};
      end
      MOP_SB: begin
        bus.size  = SZ_BYTE;
        bus.wdata = {4{reg2_i[7:0]}};
      end
      MOP_SH: begin
        bus.size  = SZ_HALF;
        bus.wdata = {2{reg2_i[15:0]}};
      end
      default: ;
    endcase
  end

  // big-endian lanes with offset 0 as the top byte
  always_comb begin
    case (offset)
      2'd0:    rd_byte = rdata[31:24];
      2'd1:    rd_byte = rdata[23:16];
      2'd2:    rd_byte = rdata[15:8];
      default: rd_byte = rdata[7:0];
    endcase
  end

  assign rd_half = offset[1] ? rdata[15:0] : rdata[31:16];

  always_comb begin
    case (aluop_i)
      MOP_LB:  result_o = {{24{rd_byte[7]}}, rd_byte};
      MOP_LBU: result_o = {24'd0, rd_byte};
      MOP_LH:  result_o = {{16{rd_half[15]}}, rd_half};
      MOP_LHU: result_o = {16'd0, rd_half};
      MOP_LW:  result_o = rdata;
      MOP_LWL: begin
        // memory fills from the left
        case (offset)
          2'd0:    result_o = rdata;
          2'd1:    result_o = {rdata[23:0], reg2_i[7:0]};
          2'd2:    result_o = {rdata[15:0], reg2_i[15:0]};
          default: result_o = {rdata[7:0], reg2_i[23:0]};
        endcase
      end
      MOP_LWR: begin
        // memory fills from the right
        case (offset)
          2'd0:    result_o = {reg2_i[31:8], rdata[31:24]};
          2'd1:    result_o = {reg2_i[31:16], rdata[31:16]};
          2'd2:    result_o = {reg2_i[31:24], rdata[31:8]};
          default: result_o = rdata;
        endcase
      end
      default: result_o = wdata_i;
    endcase
  end

endmodule

//--- source/mem_stage_top.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mem_stage_top
  import mips_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // from EX
  input  mem_op_t                aluop_i,
  input  logic [`RegAddrBus-1:0] wd_i,
  input  logic                   wreg_i,
  input  logic [`RegBus-1:0]     wdata_i,
  input  logic [`RegBus-1:0]     mem_addr_i,
  input  logic [`RegBus-1:0]     reg2_i,
  input  logic                   whilo_i,
  input  logic [`RegBus-1:0]     hi_i,
  input  logic [`RegBus-1:0]     lo_i,
  input  logic                   cp0_we_i,
  input  logic [`RegAddrBus-1:0] cp0_waddr_i,
  input  logic [`RegBus-1:0]     cp0_wdata_i,
  input  logic [31:0]            except_i,
  input  logic [`RegBus-1:0]     pc_i,
  // cp0 state
  input  logic [`RegBus-1:0]     cp0_status_i,
  input  logic [`RegBus-1:0]     cp0_cause_i,
  input  logic [`RegBus-1:0]     cp0_epc_i,
  // cp0 write in writeback
  input  logic                   wb_cp0_we_i,
  input  logic [`RegAddrBus-1:0] wb_cp0_waddr_i,
  input  logic [`RegBus-1:0]     wb_cp0_wdata_i,
  output logic                   stall_o,
  output logic [`RegAddrBus-1:0] mw_wd_o,
  output logic                   mw_wreg_o,
  output logic [`RegBus-1:0]     mw_wdata_o,
  output logic                   mw_whilo_o,
  output logic [`RegBus-1:0]     mw_hi_o,
  output logic [`RegBus-1:0]     mw_lo_o,
  output logic                   mw_cp0_we_o,
  output logic [`RegAddrBus-1:0] mw_cp0_waddr_o,
  output logic [`RegBus-1:0]     mw_cp0_wdata_o,
  output logic                   except_valid_o,
  output exc_code_t              except_code_o,
  output logic [`RegBus-1:0]     epc_o,
  output logic [`RegBus-1:0]     bad_pc_o
);

  logic               kill;
  logic [`RegBus-1:0] result;

  data_bus_if dbus ();

  mem_except except0 (
    .rst            (rst),
    .aluop_i        (aluop_i),
    .mem_addr_i     (mem_addr_i),
    .except_i       (except_i),
    .cp0_status_i   (cp0_status_i),
    .cp0_cause_i    (cp0_cause_i),
    .cp0_epc_i      (cp0_epc_i),
    .wb_cp0_we_i    (wb_cp0_we_i),
    .wb_cp0_waddr_i (wb_cp0_waddr_i),
    .wb_cp0_wdata_i (wb_cp0_wdata_i),
    .kill_o         (kill),
    .code_o         (except_code_o),
    .epc_o          (epc_o)
  );

  mem_lsu lsu0 (
    .clk        (clk),
    .rst        (rst),
    .aluop_i    (aluop_i),
    .mem_addr_i (mem_addr_i),
    .reg2_i     (reg2_i),
    .wdata_i    (wdata_i),
    .kill_i     (kill),
    .bus        (dbus.master),
    .stall_o    (stall_o),
    .result_o   (result)
  );

  data_ram ram0 (
    .clk (clk),
    .rst (rst),
    .bus (dbus.slave)
  );

  mem_wb_reg mwreg0 (
    .clk            (clk),
    .rst            (rst),
    .stall_i        (stall_o),
    .kill_i         (kill),
    .wd_i           (wd_i),
    .wreg_i         (wreg_i),
    .whilo_i        (whilo_i),
    .hi_i           (hi_i),
    .lo_i           (lo_i),
    .cp0_we_i       (cp0_we_i),
    .cp0_waddr_i    (cp0_waddr_i),
    .cp0_wdata_i    (cp0_wdata_i),
    .result_i       (result),
    .mw_wd_o        (mw_wd_o),
    .mw_wreg_o      (mw_wreg_o),
    .mw_wdata_o     (mw_wdata_o),
    .mw_whilo_o     (mw_whilo_o),
    .mw_hi_o        (mw_hi_o),
    .mw_lo_o        (mw_lo_o),
    .mw_cp0_we_o    (mw_cp0_we_o),
    .mw_cp0_waddr_o (mw_cp0_waddr_o),
    .mw_cp0_wdata_o (mw_cp0_wdata_o)
  );

  assign except_valid_o = kill;
  assign bad_pc_o       = pc_i;

endmodule

//--- source/mem_wb_reg.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mem_wb_reg (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_i,
  input  logic                   kill_i,
  input  logic [`RegAddrBus-1:0] wd_i,
  input  logic                   wreg_i,
  input  logic                   whilo_i,
  input  logic [`RegBus-1:0]     hi_i,
  input  logic [`RegBus-1:0]     lo_i,
  input  logic                   cp0_we_i,
  input  logic [`RegAddrBus-1:0] cp0_waddr_i,
  input  logic [`RegBus-1:0]     cp0_wdata_i,
  input  logic [`RegBus-1:0]     result_i,
  output logic [`RegAddrBus-1:0] mw_wd_o,
  output logic                   mw_wreg_o,
  output logic [`RegBus-1:0]     mw_wdata_o,
  output logic                   mw_whilo_o,
  output logic [`RegBus-1:0]     mw_hi_o,
  output logic [`RegBus-1:0]     mw_lo_o,
  output logic                   mw_cp0_we_o,
  output logic [`RegAddrBus-1:0] mw_cp0_waddr_o,
  output logic [`RegBus-1:0]     mw_cp0_wdata_o
);

  logic bubble;

  assign bubble = stall_i || kill_i;

  // write enables, cleared for a bubble
  always_ff @(posedge clk) begin
    if (rst || bubble) begin
      mw_wreg_o   <= 1'b0;
      mw_whilo_o  <= 1'b0;
      mw_cp0_we_o <= 1'b0;
    end else begin
      mw_wreg_o   <= wreg_i;
      mw_whilo_o  <= whilo_i;
      mw_cp0_we_o <= cp0_we_i;
    end
  end

  always_ff @(posedge clk) begin
    mw_wd_o        <= wd_i;
    mw_wdata_o     <= result_i;
    mw_hi_o        <= hi_i;
    mw_lo_o        <= lo_i;
    mw_cp0_waddr_o <= cp0_waddr_i;
    mw_cp0_wdata_o <= cp0_wdata_i;
  end

endmodule

//--- source/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath widths
`define RegBus      32
`define RegAddrBus  5

// cp0 register numbers
`define CP0_REG_STATUS  5'd12
`define CP0_REG_CAUSE   5'd13
`define CP0_REG_EPC     5'd14

// data ram word-address bits, 4 KB
`define RAM_ADDR_BITS   10

`endif

//--- source/mips_pkg.sv
package mips_pkg;

  // memory opcode from EX
  typedef enum logic [3:0] {
    MOP_NONE = 4'd0,
    MOP_LB   = 4'd1,
    MOP_LBU  = 4'd2,
    MOP_LH   = 4'd3,
    MOP_LHU  = 4'd4,
    MOP_LW   = 4'd5,
    MOP_LWL  = 4'd6,
    MOP_LWR  = 4'd7,
    MOP_SB   = 4'd8,
    MOP_SH   = 4'd9,
    MOP_SW   = 4'd10
  } mem_op_t;

  // MIPS cause codes, no-exception takes an unused code
  typedef enum logic [4:0] {
    EXC_INT  = 5'd0,
    EXC_ADEL = 5'd4,
    EXC_ADES = 5'd5,
    EXC_SYS  = 5'd8,
    EXC_RI   = 5'd10,
    EXC_OV   = 5'd12,
    EXC_TR   = 5'd13,
    EXC_ERET = 5'd14,
    EXC_NONE = 5'd31
  } exc_code_t;

  // access size on the data bus
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } bus_size_t;

endpackage

//--- sources.f
+incdir+source
source/mips_pkg.sv
source/data_bus_if.sv
source/mem_lsu.sv
source/mem_except.sv
source/data_ram.sv
source/mem_wb_reg.sv
source/mem_stage_top.sv
verification/mem_stage_asserts.sv
verification/mem_stage_tb.sv

//--- verification/mem_stage_asserts.sv
`timescale 1ns/1ps

module mem_stage_asserts (
  input logic clk,
  input logic rst,
  input logic req_i,
  input logic addr_ok_i,
  input logic data_ok_i,
  input logic stall_i
);

  int unsigned fail_count = 0;

  // one request in flight at a time
  no_req_after_accept: assert property (@(posedge clk) disable iff (rst)
    (req_i && addr_ok_i) |=> !req_i)
    else begin
      $error("req raised while a request is outstanding");
      fail_count++;
    end

  data_ok_after_accept: assert property (@(posedge clk) disable iff (rst)
    (req_i && addr_ok_i) |=> data_ok_i)
    else begin
      $error("data_ok missing one cycle after acceptance");
      fail_count++;
    end

  data_ok_only_after_accept: assert property (@(posedge clk) disable iff (rst)
    data_ok_i |-> $past(req_i && addr_ok_i))
    else begin
      $error("data_ok without an accepted request");
      fail_count++;
    end

  stall_low_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !stall_i)
    else begin
      $error("stall high right after reset");
      fail_count++;
    end

endmodule

bind mem_stage_top mem_stage_asserts asserts0 (
  .clk       (clk),
  .rst       (rst),
  .req_i     (dbus.req),
  .addr_ok_i (dbus.addr_ok),
  .data_ok_i (dbus.data_ok),
  .stall_i   (stall_o)
);

//--- verification/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb
  import mips_pkg::*;
();

  // about 60 ops of at most 3 cycles plus margin
  localparam int unsigned TIMEOUT_CYCLES = 400;

  logic        clk = 1'b0;
  logic        rst;
  mem_op_t     aluop_i;
  logic [4:0]  wd_i, cp0_waddr_i, wb_cp0_waddr_i;
  logic        wreg_i, whilo_i, cp0_we_i, wb_cp0_we_i;
  logic [31:0] wdata_i, mem_addr_i, reg2_i, hi_i, lo_i, cp0_wdata_i;
  logic [31:0] except_i, pc_i, cp0_status_i, cp0_cause_i, cp0_epc_i, wb_cp0_wdata_i;
  logic        stall_o, mw_wreg_o, mw_whilo_o, mw_cp0_we_o, except_valid_o;
  logic [4:0]  mw_wd_o, mw_cp0_waddr_o;
  logic [31:0] mw_wdata_o, mw_hi_o, mw_lo_o, mw_cp0_wdata_o, epc_o, bad_pc_o;
  exc_code_t   except_code_o;

  logic [31:0] img [0:1023];
  logic [31:0] lfsr_state = 32'h8665;
  int unsigned cycle_cnt = 0;

  mem_stage_top dut0 (.*);

  always #4 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      stop_with_failure("timeout: the stage never finished its instruction");
    end else if (dut0.asserts0.fail_count != 0) begin
      stop_with_failure("a bus or stall assertion failed");
    end
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_code(input string name, input exc_code_t exp, input exc_code_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  // byte k counted from the top in big-endian order
  function automatic logic [7:0] byte_at(input logic [31:0] w, input int k);
    return w[31-8*k -: 8];
  endfunction

  function automatic logic [31:0] put_byte(input logic [31:0] w, input int k,
                                           input logic [7:0] b);
    w[31-8*k -: 8] = b;
    return w;
  endfunction

  function automatic logic [31:0] expected_load(input mem_op_t op, input logic [31:0] w,
                                                input logic [1:0] k, input logic [31:0] r2);
    logic [31:0] r;
    logic [7:0]  b;
    logic [15:0] h;
    int          kk;
    kk = k;
    r = w;
    b = byte_at(w, kk);
    case (op)
      MOP_LB:  r = {{24{b[7]}}, b};
      MOP_LBU: r = {24'd0, b};
      MOP_LH, MOP_LHU: begin
        h = {byte_at(w, kk), byte_at(w, kk + 1)};
        r = (op == MOP_LH) ? {{16{h[15]}}, h} : {16'd0, h};
      end
      MOP_LWL: begin
        r = r2;
        for (int i = 0; i + kk <= 3; i++) r = put_byte(r, i, byte_at(w, i + kk));
      end
      MOP_LWR: begin
        r = r2;
        for (int i = 3 - kk; i <= 3; i++) r = put_byte(r, i, byte_at(w, i - 3 + kk));
      end
      default: r = w;
    endcase
    return r;
  endfunction

  task automatic present(input mem_op_t op, input logic [31:0] addr,
                         input logic [31:0] r2, input logic wreg);
    aluop_i    = op;
    mem_addr_i = addr;
    reg2_i     = r2;
    wreg_i     = wreg;
    wd_i       = 5'(lfsr_bits(5));
    pc_i       = lfsr_bits(32);
  endtask

  // count stall cycles until the result is in the MEM/WB register
  task automatic wait_done(input int exp_stalls);
    int stalls;
    stalls = 0;
    @(negedge clk);
    while (stall_o) begin
      stalls++;
      @(negedge clk);
      check_word("mw_wreg_o during stall", 1'b0, mw_wreg_o);
    end
    @(posedge clk);
    #1;
    check_word("stall cycles", exp_stalls, stalls);
  endtask

  task automatic do_store(input mem_op_t op, input logic [31:0] addr, input logic [31:0] d);
    int w;
    int k;
    w = addr[11:2];
    k = addr[1:0];
    case (op)
      MOP_SB: img[w] = put_byte(img[w], k, d[7:0]);
      MOP_SH: img[w] = put_byte(put_byte(img[w], k, d[15:8]), k + 1, d[7:0]);
      default: img[w] = d;
    endcase
    present(op, addr, d, 1'b0);
    wait_done(1);
  endtask

  task automatic do_load(input mem_op_t op, input logic [31:0] addr, input logic [31:0] r2);
    logic [31:0] exp;
    exp = expected_load(op, img[addr[11:2]], addr[1:0], r2);
    present(op, addr, r2, 1'b1);
    wait_done(1);
    check_word("mw_wreg_o", 1'b1, mw_wreg_o);
    check_word("mw_wd_o", wd_i, mw_wd_o);
    check_word("mw_wdata_o", exp, mw_wdata_o);
  endtask

  task automatic expect_exception(input mem_op_t op, input logic [31:0] addr,
                                  input logic [31:0] flags, input exc_code_t code);
    present(op, addr, 32'hffff_ffff, 1'b1);
    whilo_i  = 1'b1;
    cp0_we_i = 1'b1;
    except_i = flags;
    @(negedge clk);
    check_code("except_code_o", code, except_code_o);
    check_word("except_valid_o", 1'b1, except_valid_o);
    check_word("stall_o", 1'b0, stall_o);
    check_word("bad_pc_o", pc_i, bad_pc_o);
    @(posedge clk);
    #1;
    check_word("mw_wreg_o", 1'b0, mw_wreg_o);
    check_word("mw_whilo_o", 1'b0, mw_whilo_o);
    check_word("mw_cp0_we_o", 1'b0, mw_cp0_we_o);
    whilo_i  = 1'b0;
    cp0_we_i = 1'b0;
    except_i = '0;
  endtask

  task automatic test_store_load();
    do_store(MOP_SW, 32'h100, lfsr_bits(32));
    do_load(MOP_LW, 32'h100, 32'h0);
  endtask

  task automatic test_subword();
    do_store(MOP_SW, 32'h200, lfsr_bits(32));
    do_store(MOP_SB, 32'h201, lfsr_bits(32));
    // force a negative half so sign extension shows
    do_store(MOP_SH, 32'h202, lfsr_bits(32) | 32'h8000);
    for (int k = 0; k < 4; k++) begin
      do_load(MOP_LB, 32'h200 + k, lfsr_bits(32));
      do_load(MOP_LBU, 32'h200 + k, lfsr_bits(32));
    end
    for (int k = 0; k < 4; k += 2) begin
      do_load(MOP_LH, 32'h200 + k, lfsr_bits(32));
      do_load(MOP_LHU, 32'h200 + k, lfsr_bits(32));
    end
  endtask

  task automatic test_unaligned_merge();
    do_store(MOP_SW, 32'h300, lfsr_bits(32));
    for (int k = 0; k < 4; k++) begin
      do_load(MOP_LWL, 32'h300 + k, 32'h5a5a_a5a5);
      do_load(MOP_LWR, 32'h300 + k, 32'h5a5a_a5a5);
    end
  endtask

  task automatic test_passthrough();
    present(MOP_NONE, 32'h0, 32'h0, 1'b1);
    wdata_i     = lfsr_bits(32);
    whilo_i     = 1'b1;
    hi_i        = lfsr_bits(32);
    lo_i        = lfsr_bits(32);
    cp0_we_i    = 1'b1;
    cp0_waddr_i = 5'd14;
    cp0_wdata_i = lfsr_bits(32);
    wait_done(0);
    check_word("mw_wd_o", wd_i, mw_wd_o);
    check_word("mw_wreg_o", 1'b1, mw_wreg_o);
    check_word("mw_wdata_o", wdata_i, mw_wdata_o);
    check_word("mw_whilo_o", 1'b1, mw_whilo_o);
    check_word("mw_hi_o", hi_i, mw_hi_o);
    check_word("mw_lo_o", lo_i, mw_lo_o);
    check_word("mw_cp0_we_o", 1'b1, mw_cp0_we_o);
    check_word("mw_cp0_waddr_o", cp0_waddr_i, mw_cp0_waddr_o);
    check_word("mw_cp0_wdata_o", cp0_wdata_i, mw_cp0_wdata_o);
    whilo_i  = 1'b0;
    cp0_we_i = 1'b0;
  endtask

  task automatic test_priority();
    expect_exception(MOP_NONE, 32'h0, 32'h0000_1f00, EXC_SYS);
    expect_exception(MOP_NONE, 32'h0, 32'h0000_1e00, EXC_RI);
    expect_exception(MOP_NONE, 32'h0, 32'h0000_1c00, EXC_TR);
    expect_exception(MOP_NONE, 32'h0, 32'h0000_1800, EXC_OV);
    expect_exception(MOP_NONE, 32'h0, 32'h0000_1000, EXC_ERET);
    expect_exception(MOP_LW, 32'h101, 32'h0000_0100, EXC_ADEL);
    // misaligned accesses must leave memory alone
    expect_exception(MOP_LW, 32'h102, 32'h0, EXC_ADEL);
    expect_exception(MOP_SH, 32'h201, 32'h0, EXC_ADES);
    do_load(MOP_LW, 32'h200, 32'h0);
    do_load(MOP_LW, 32'h100, 32'h0);
  endtask

  task automatic test_forwarding();
    cp0_cause_i    = 32'h0000_0400;
    wb_cp0_we_i    = 1'b1;
    wb_cp0_waddr_i = 5'd12;
    wb_cp0_wdata_i = 32'h0000_0401;
    expect_exception(MOP_NONE, 32'h0, 32'h0, EXC_INT);
    // software interrupt bit arriving through a cause write
    cp0_cause_i    = 32'h0;
    cp0_status_i   = 32'h0000_0101;
    wb_cp0_waddr_i = 5'd13;
    wb_cp0_wdata_i = 32'h0000_0100;
    expect_exception(MOP_NONE, 32'h0, 32'h0, EXC_INT);
    cp0_status_i   = 32'h0;
    cp0_epc_i      = 32'hbfc0_0000;
    wb_cp0_waddr_i = 5'd14;
    wb_cp0_wdata_i = lfsr_bits(32);
    present(MOP_NONE, 32'h0, 32'h0, 1'b0);
    @(negedge clk);
    check_word("epc_o", wb_cp0_wdata_i, epc_o);
    check_code("except_code_o", EXC_NONE, except_code_o);
    @(posedge clk);
    #1;
    wb_cp0_we_i = 1'b0;
    // without a writeback write the cp0 value shows through
    @(negedge clk);
    check_word("epc_o", cp0_epc_i, epc_o);
    @(posedge clk);
    #1;
  endtask

  initial begin
    rst            = 1'b1;
    aluop_i        = MOP_NONE;
    wd_i           = '0;
    wreg_i         = 1'b0;
    wdata_i        = '0;
    mem_addr_i     = '0;
    reg2_i         = '0;
    whilo_i        = 1'b0;
    hi_i           = '0;
    lo_i           = '0;
    cp0_we_i       = 1'b0;
    cp0_waddr_i    = '0;
    cp0_wdata_i    = '0;
    except_i       = '0;
    pc_i           = '0;
    cp0_status_i   = '0;
    cp0_cause_i    = '0;
    cp0_epc_i      = '0;
    wb_cp0_we_i    = 1'b0;
    wb_cp0_waddr_i = '0;
    wb_cp0_wdata_i = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    test_store_load();
    test_subword();
    test_unaligned_merge();
    test_passthrough();
    test_priority();
    test_forwarding();
    aluop_i = MOP_NONE;
    repeat (2) @(posedge clk);
    #1;
    if (dut0.asserts0.fail_count != 0) begin
      stop_with_failure("bus or stall assertions failed during the run");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule
